//--- src/rv_isa_pkg.sv
package rv_isa_pkg;

  // Major opcodes of the control transfer instructions
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;
  localparam logic [6:0] OPC_JALR   = 7'b1100111;

  // Branch condition codes in funct3
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  // Signed compares
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  // Unsigned compares
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  // Control-flow kind of an instruction in EX
  // CF_NONE covers every non-control opcode
  typedef enum logic [1:0] {
    // Plain instruction, falls through
    CF_NONE   = 2'd0,
    // Conditional branch, B-type immediate
    CF_BRANCH = 2'd1,
    // Direct jump, J-type immediate
    CF_JAL    = 2'd2,
    // Register indirect jump, I-type immediate
    CF_JALR   = 2'd3
  } cf_kind_t;

endpackage

//--- src/rv_bpred_pkg.sv
package rv_bpred_pkg;

  // Two-bit saturating direction counter
  typedef logic [1:0] ctr_t;

  // Counter states, ordered so that increment means more taken
  // Strongly not taken
  localparam ctr_t CTR_SNT = 2'b00;
  // Weakly not taken
  localparam ctr_t CTR_WNT = 2'b01;
  // Weakly taken
  localparam ctr_t CTR_WT  = 2'b10;
  // Strongly taken
  localparam ctr_t CTR_ST  = 2'b11;

  // Default BTB size is 2**4 = 16 entries
  localparam int BTB_IDX_BITS_DEFAULT = 4;

endpackage

//--- src/rv_branch_decode.sv
`timescale 1ns/1ps

module rv_branch_decode #(
  parameter int XLEN = 32
) (
  input  logic [31:0]          instr,
  output rv_isa_pkg::cf_kind_t cf_kind,
  output logic [4:0]           rd,
  output logic [2:0]           funct3,
  output logic [XLEN-1:0]      imm
);

  logic [6:0]      opcode;
  logic [XLEN-1:0] imm_b;
  logic [XLEN-1:0] imm_j;
  logic [XLEN-1:0] imm_i;

  // Fixed instruction fields
  assign opcode = instr[6:0];
  assign rd     = instr[11:7];
  assign funct3 = instr[14:12];

  // B-type immediate, bit 0 always zero
  // imm[12|10:5] in [31:25], imm[4:1|11] in [11:7]
  assign imm_b = {{(XLEN-12){instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};

  // J-type immediate, +/- 1 MiB range
  assign imm_j = {{(XLEN-20){instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

  // I-type immediate used by JALR
  assign imm_i = {{(XLEN-11){instr[31]}}, instr[30:20]};

  // Classify by major opcode only
  always_comb begin
    cf_kind = rv_isa_pkg::CF_NONE;
    imm     = '0;
    case (opcode)
      rv_isa_pkg::OPC_BRANCH: begin
        cf_kind = rv_isa_pkg::CF_BRANCH;
        imm     = imm_b;
      end
      rv_isa_pkg::OPC_JAL: begin
        cf_kind = rv_isa_pkg::CF_JAL;
        imm     = imm_j;
      end
      rv_isa_pkg::OPC_JALR: begin
        cf_kind = rv_isa_pkg::CF_JALR;
        imm     = imm_i;
      end
      default: begin
        // Not a control transfer, immediate is don't care
        cf_kind = rv_isa_pkg::CF_NONE;
        imm     = '0;
      end
    endcase
  end

endmodule

//--- src/rv_branch_execute.sv
`timescale 1ns/1ps

module rv_branch_execute #(
  parameter int XLEN = 32
) (
  input  rv_isa_pkg::cf_kind_t cf_kind,
  input  logic [2:0]           funct3,
  input  logic [XLEN-1:0]      imm,
  input  logic [XLEN-1:0]      pc,
  input  logic [XLEN-1:0]      rs1,
  input  logic [XLEN-1:0]      rs2,
  output logic                 actual_taken,
  output logic [XLEN-1:0]      actual_target,
  output logic [XLEN-1:0]      pc_plus4
);

  logic            cond_true;
  logic [XLEN-1:0] pc_rel_target;
  logic [XLEN-1:0] reg_target;

  // Fall-through address of the instruction
  assign pc_plus4 = pc + XLEN'(4);

  // PC relative target shared by branches and JAL
  assign pc_rel_target = pc + imm;

  // JALR target has bit 0 cleared by the ISA
  assign reg_target = (rs1 + imm) & ~XLEN'(1);

  // Branch condition from funct3
  always_comb begin
    case (funct3)
      rv_isa_pkg::F3_BEQ:  cond_true = (rs1 == rs2);
      rv_isa_pkg::F3_BNE:  cond_true = (rs1 != rs2);
      rv_isa_pkg::F3_BLT:  cond_true = ($signed(rs1) < $signed(rs2));
      rv_isa_pkg::F3_BGE:  cond_true = ($signed(rs1) >= $signed(rs2));
      rv_isa_pkg::F3_BLTU: cond_true = (rs1 < rs2);
      rv_isa_pkg::F3_BGEU: cond_true = (rs1 >= rs2);
      // Reserved encodings never branch
      default:             cond_true = 1'b0;
    endcase
  end

  // Outcome and target per control-flow kind
  always_comb begin
    case (cf_kind)
      rv_isa_pkg::CF_BRANCH: begin
        actual_taken  = cond_true;
        // Target kept even when not taken, BTB stores it for later
        actual_target = pc_rel_target;
      end
      rv_isa_pkg::CF_JAL: begin
        actual_taken  = 1'b1;
        actual_target = pc_rel_target;
      end
      rv_isa_pkg::CF_JALR: begin
        actual_taken  = 1'b1;
        actual_target = reg_target;
      end
      default: begin
        actual_taken  = 1'b0;
        actual_target = pc_plus4;
      end
    endcase
  end

endmodule

//--- src/rv_bpred_ex.sv
`timescale 1ns/1ps

module rv_bpred_ex #(
  parameter int XLEN       = 32,
  parameter int BTB_ENABLE = 1
) (
  input  logic                 valid,
  input  rv_isa_pkg::cf_kind_t cf_kind,
  input  logic [4:0]           rd,
  input  logic [XLEN-1:0]      pc,
  input  logic                 actual_taken,
  input  logic [XLEN-1:0]      actual_target,
  output logic                 btb_update_en,
  output logic [XLEN-1:0]      btb_update_pc,
  output logic [XLEN-1:0]      btb_update_target,
  output logic                 btb_update_taken,
  output logic                 btb_update_is_ret,
  output logic                 btb_update_is_jal
);

  if (BTB_ENABLE != 0) begin : g_update
    logic is_branch;
    logic is_jal;
    logic is_ret;

    assign is_branch = (cf_kind == rv_isa_pkg::CF_BRANCH);
    assign is_jal    = (cf_kind == rv_isa_pkg::CF_JAL);

    // Return or tail call: indirect jump that links nothing
    // Other JALRs have data dependent targets and stay out of the BTB
    assign is_ret = (cf_kind == rv_isa_pkg::CF_JALR) && (rd == 5'd0);

    // Train only on a valid slot holding a predictable kind
    assign btb_update_en     = valid && (is_branch || is_jal || is_ret);
    assign btb_update_pc     = pc;
    assign btb_update_target = actual_target;
    assign btb_update_is_ret = is_ret;
    assign btb_update_is_jal = is_jal;

    // Unconditional jumps always train toward taken
    assign btb_update_taken = (is_jal || is_ret) ? 1'b1 : actual_taken;

  end else begin : g_no_update
    // BTB never written, so every lookup misses
    assign btb_update_en     = 1'b0;
    assign btb_update_pc     = '0;
    assign btb_update_target = '0;
    assign btb_update_taken  = 1'b0;
    assign btb_update_is_ret = 1'b0;
    assign btb_update_is_jal = 1'b0;
  end

endmodule

//--- src/rv_btb.sv
`timescale 1ns/1ps

module rv_btb #(
  parameter int XLEN         = 32,
  parameter int BTB_IDX_BITS = 4
) (
  input  logic            clk,
  input  logic            arst_n,
  // Fetch lookup, combinational
  input  logic [XLEN-1:0] lookup_pc,
  output logic            hit,
  output logic            taken,
  output logic [XLEN-1:0] target,
  output logic            is_ret,
  // Training from EX, written at the clock edge
  input  logic            update_en,
  input  logic [XLEN-1:0] update_pc,
  input  logic [XLEN-1:0] update_target,
  input  logic            update_taken,
  input  logic            update_is_ret,
  input  logic            update_is_jal
);

  localparam int ENTRIES  = 1 << BTB_IDX_BITS;
  // Two low pc bits are always zero for 32-bit instructions
  localparam int TAG_BITS = XLEN - BTB_IDX_BITS - 2;

  // Control state
  logic [ENTRIES-1:0] valid_q;

  // Entry payload, no reset
  logic [TAG_BITS-1:0]     tag_mem    [ENTRIES];
  logic [XLEN-1:0]         target_mem [ENTRIES];
  rv_bpred_pkg::ctr_t      ctr_mem    [ENTRIES];
  logic [ENTRIES-1:0]      ret_mem;
  logic [ENTRIES-1:0]      jal_mem;

  logic [BTB_IDX_BITS-1:0] lk_idx;
  logic [TAG_BITS-1:0]     lk_tag;
  rv_bpred_pkg::ctr_t      lk_ctr;
  logic                    lk_ctr_taken;

  logic [BTB_IDX_BITS-1:0] upd_idx;
  logic [TAG_BITS-1:0]     upd_tag;
  logic                    upd_hit;
  rv_bpred_pkg::ctr_t      upd_ctr_cur;
  rv_bpred_pkg::ctr_t      upd_ctr_next;

  // Lookup
  assign lk_idx = lookup_pc[BTB_IDX_BITS+1:2];
  assign lk_tag = lookup_pc[XLEN-1:BTB_IDX_BITS+2];
  assign lk_ctr = ctr_mem[lk_idx];

  // Upper half of the counter range predicts taken
  assign lk_ctr_taken = (lk_ctr == rv_bpred_pkg::CTR_WT) || (lk_ctr == rv_bpred_pkg::CTR_ST);

  assign hit    = valid_q[lk_idx] && (tag_mem[lk_idx] == lk_tag);
  // Jumps are taken whatever the counter says
  assign taken  = hit && (jal_mem[lk_idx] || ret_mem[lk_idx] || lk_ctr_taken);
  assign target = target_mem[lk_idx];
  assign is_ret = hit && ret_mem[lk_idx];

  // Update side decode
  assign upd_idx     = update_pc[BTB_IDX_BITS+1:2];
  assign upd_tag     = update_pc[XLEN-1:BTB_IDX_BITS+2];
  assign upd_hit     = valid_q[upd_idx] && (tag_mem[upd_idx] == upd_tag);
  assign upd_ctr_cur = ctr_mem[upd_idx];

  // Next counter value
  always_comb begin
    if (update_is_jal || update_is_ret) begin
      upd_ctr_next = rv_bpred_pkg::CTR_ST;
    end else if (!upd_hit) begin
      // Fresh allocation starts weak, in the observed direction
      upd_ctr_next = update_taken ? rv_bpred_pkg::CTR_WT : rv_bpred_pkg::CTR_WNT;
    end else if (update_taken) begin
      // Saturate at strongly taken
      upd_ctr_next = (upd_ctr_cur == rv_bpred_pkg::CTR_ST) ?
                     upd_ctr_cur : rv_bpred_pkg::ctr_t'(upd_ctr_cur + 2'd1);
    end else begin
      // Saturate at strongly not taken
      upd_ctr_next = (upd_ctr_cur == rv_bpred_pkg::CTR_SNT) ?
                     upd_ctr_cur : rv_bpred_pkg::ctr_t'(upd_ctr_cur - 2'd1);
    end
  end

  // Valid bits, cleared asynchronously
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= '0;
    end else if (update_en) begin
      valid_q[upd_idx] <= 1'b1;
    end
  end

  // Payload write, a tag miss simply overwrites the old entry
  always_ff @(posedge clk) begin
    if (update_en) begin
      tag_mem[upd_idx]    <= upd_tag;
      target_mem[upd_idx] <= update_target;
      ctr_mem[upd_idx]    <= upd_ctr_next;
      ret_mem[upd_idx]    <= update_is_ret;
      jal_mem[upd_idx]    <= update_is_jal;
    end
  end

endmodule

//--- src/rv_bpred_mem.sv
`timescale 1ns/1ps

module rv_bpred_mem #(
  parameter int XLEN = 32
) (
  input  logic            clk,
  input  logic            arst_n,
  // Resolution and prediction from EX
  input  logic            ex_valid,
  input  logic            actual_taken,
  input  logic [XLEN-1:0] actual_target,
  input  logic [XLEN-1:0] pc_plus4,
  input  logic            pred_taken,
  input  logic [XLEN-1:0] pred_target,
  // MEM result, one cycle after EX
  output logic            mem_valid,
  output logic            mem_mispredict,
  output logic [XLEN-1:0] mem_redirect_pc
);

  logic            valid_q;
  logic            actual_taken_q;
  logic [XLEN-1:0] actual_target_q;
  logic [XLEN-1:0] pc_plus4_q;
  logic            pred_taken_q;
  logic [XLEN-1:0] pred_target_q;

  logic            dir_wrong;
  logic            target_wrong;

  // Slot valid bit
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= ex_valid;
    end
  end

  // EX payload captured every cycle
  always_ff @(posedge clk) begin
    actual_taken_q  <= actual_taken;
    actual_target_q <= actual_target;
    pc_plus4_q      <= pc_plus4;
    pred_taken_q    <= pred_taken;
    pred_target_q   <= pred_target;
  end

  // Compare after the register, away from the EX adders
  assign dir_wrong    = (actual_taken_q != pred_taken_q);
  // Right direction but wrong place
  assign target_wrong = actual_taken_q && pred_taken_q && (actual_target_q != pred_target_q);

  assign mem_valid       = valid_q;
  assign mem_mispredict  = valid_q && (dir_wrong || target_wrong);
  // Not taken resumes at the fall-through
  assign mem_redirect_pc = actual_taken_q ? actual_target_q : pc_plus4_q;

endmodule

//--- src/rv_bpred_unit.sv
`timescale 1ns/1ps

module rv_bpred_unit #(
  parameter int XLEN         = 32,
  parameter int BTB_IDX_BITS = rv_bpred_pkg::BTB_IDX_BITS_DEFAULT,
  parameter int BTB_ENABLE   = 1
) (
  input  logic            clk,
  input  logic            arst_n,
  // Fetch prediction
  input  logic [XLEN-1:0] fetch_pc,
  output logic            pred_hit,
  output logic            pred_taken,
  output logic [XLEN-1:0] pred_target,
  output logic            pred_is_ret,
  // EX slot
  input  logic            ex_valid,
  input  logic [31:0]     ex_instr,
  input  logic [XLEN-1:0] ex_pc,
  input  logic [XLEN-1:0] ex_rs1,
  input  logic [XLEN-1:0] ex_rs2,
  input  logic            ex_pred_taken,
  input  logic [XLEN-1:0] ex_pred_target,
  // MEM result
  output logic            mem_valid,
  output logic            mem_mispredict,
  output logic [XLEN-1:0] mem_redirect_pc
);

  // Decode results
  rv_isa_pkg::cf_kind_t cf_kind;
  logic [4:0]           rd;
  logic [2:0]           funct3;
  logic [XLEN-1:0]      imm;

  // Resolved outcome
  logic                 actual_taken;
  logic [XLEN-1:0]      actual_target;
  logic [XLEN-1:0]      pc_plus4;

  // BTB training
  logic                 btb_update_en;
  logic [XLEN-1:0]      btb_update_pc;
  logic [XLEN-1:0]      btb_update_target;
  logic                 btb_update_taken;
  logic                 btb_update_is_ret;
  logic                 btb_update_is_jal;

  rv_branch_decode #(
    .XLEN(XLEN)
  ) rv_branch_decode_i (
    .instr  (ex_instr),
    .cf_kind(cf_kind),
    .rd     (rd),
    .funct3 (funct3),
    .imm    (imm)
  );

  rv_branch_execute #(
    .XLEN(XLEN)
  ) rv_branch_execute_i (
    .cf_kind      (cf_kind),
    .funct3       (funct3),
    .imm          (imm),
    .pc           (ex_pc),
    .rs1          (ex_rs1),
    .rs2          (ex_rs2),
    .actual_taken (actual_taken),
    .actual_target(actual_target),
    .pc_plus4     (pc_plus4)
  );

  rv_bpred_ex #(
    .XLEN      (XLEN),
    .BTB_ENABLE(BTB_ENABLE)
  ) rv_bpred_ex_i (
    .valid            (ex_valid),
    .cf_kind          (cf_kind),
    .rd               (rd),
    .pc               (ex_pc),
    .actual_taken     (actual_taken),
    .actual_target    (actual_target),
    .btb_update_en    (btb_update_en),
    .btb_update_pc    (btb_update_pc),
    .btb_update_target(btb_update_target),
    .btb_update_taken (btb_update_taken),
    .btb_update_is_ret(btb_update_is_ret),
    .btb_update_is_jal(btb_update_is_jal)
  );

  rv_btb #(
    .XLEN        (XLEN),
    .BTB_IDX_BITS(BTB_IDX_BITS)
  ) rv_btb_i (
    .clk          (clk),
    .arst_n       (arst_n),
    .lookup_pc    (fetch_pc),
    .hit          (pred_hit),
    .taken        (pred_taken),
    .target       (pred_target),
    .is_ret       (pred_is_ret),
    .update_en    (btb_update_en),
    .update_pc    (btb_update_pc),
    .update_target(btb_update_target),
    .update_taken (btb_update_taken),
    .update_is_ret(btb_update_is_ret),
    .update_is_jal(btb_update_is_jal)
  );

  rv_bpred_mem #(
    .XLEN(XLEN)
  ) rv_bpred_mem_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .ex_valid       (ex_valid),
    .actual_taken   (actual_taken),
    .actual_target  (actual_target),
    .pc_plus4       (pc_plus4),
    .pred_taken     (ex_pred_taken),
    .pred_target    (ex_pred_target),
    .mem_valid      (mem_valid),
    .mem_mispredict (mem_mispredict),
    .mem_redirect_pc(mem_redirect_pc)
  );

endmodule

//--- tests/rv_bpred_unit_assertions.sv
`timescale 1ns/1ps

module rv_bpred_unit_assertions (
  input logic clk,
  input logic arst_n,
  input logic pred_hit,
  input logic pred_taken,
  input logic ex_valid,
  input logic mem_valid,
  input logic mem_mispredict
);

  // A taken prediction needs a BTB entry
  taken_needs_hit: assert property (@(posedge clk) disable iff (!arst_n)
    pred_taken |-> pred_hit)
    else $error("pred_taken high without pred_hit");

  // Only a valid MEM slot flags
  mispredict_needs_valid: assert property (@(posedge clk) disable iff (!arst_n)
    mem_mispredict |-> mem_valid)
    else $error("mem_mispredict high without mem_valid");

  // One cycle EX to MEM latency
  mem_follows_ex: assert property (@(posedge clk) disable iff (!arst_n)
    mem_valid == $past(ex_valid))
    else $error("mem_valid does not follow ex_valid by one cycle");

  // MEM slot empty in reset
  mem_idle_in_reset: assert property (@(posedge clk)
    !arst_n |-> !mem_valid)
    else $error("mem_valid high during reset");

endmodule

bind rv_bpred_unit rv_bpred_unit_assertions rv_bpred_unit_assertions_i (
  .clk           (clk),
  .arst_n        (arst_n),
  .pred_hit      (pred_hit),
  .pred_taken    (pred_taken),
  .ex_valid      (ex_valid),
  .mem_valid     (mem_valid),
  .mem_mispredict(mem_mispredict)
);

//--- tests/rv_bpred_unit_tb.sv
`timescale 1ns/1ps

module rv_bpred_unit_tb;

  // One row of stimulus and expected response
  // Flags are force taken prediction, hit, taken, is_ret, mispredict
  typedef struct packed {
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] rs1;
    logic [31:0] rs2;
    logic [4:0]  flags;
    logic [31:0] target;
    logic [31:0] redirect;
  } entry_t;

  logic        clk = 1'b0;
  logic        arst_n;
  logic [31:0] fetch_pc;
  logic        pred_hit;
  logic        pred_taken;
  logic [31:0] pred_target;
  logic        pred_is_ret;
  logic        ex_valid;
  logic [31:0] ex_instr;
  logic [31:0] ex_pc;
  logic [31:0] ex_rs1;
  logic [31:0] ex_rs2;
  logic        ex_pred_taken;
  logic [31:0] ex_pred_target;
  logic        mem_valid;
  logic        mem_mispredict;
  logic [31:0] mem_redirect_pc;

  entry_t table_q[$];

  rv_bpred_unit rv_bpred_unit_i (
    .clk            (clk),
    .arst_n         (arst_n),
    .fetch_pc       (fetch_pc),
    .pred_hit       (pred_hit),
    .pred_taken     (pred_taken),
    .pred_target    (pred_target),
    .pred_is_ret    (pred_is_ret),
    .ex_valid       (ex_valid),
    .ex_instr       (ex_instr),
    .ex_pc          (ex_pc),
    .ex_rs1         (ex_rs1),
    .ex_rs2         (ex_rs2),
    .ex_pred_taken  (ex_pred_taken),
    .ex_pred_target (ex_pred_target),
    .mem_valid      (mem_valid),
    .mem_mispredict (mem_mispredict),
    .mem_redirect_pc(mem_redirect_pc)
  );

  // 40 ns period
  always #20 clk = ~clk;

  function automatic void add_entry(input logic [31:0] pc, input logic [31:0] instr,
                                    input logic [31:0] rs1, input logic [31:0] rs2,
                                    input logic [4:0] flags, input logic [31:0] target,
                                    input logic [31:0] redirect);
    table_q.push_back(entry_t'{pc, instr, rs1, rs2, flags, target, redirect});
  endfunction

  function automatic void fill_table();
    // Cold branches with every condition true then false in indices 0 to 11
    add_entry(32'h1000, 32'h00208863, 32'h5, 32'h5, 5'b0_0_0_0_1, 32'h0, 32'h1010);
    add_entry(32'h1004, 32'h00208863, 32'h5, 32'h6, 5'b0_0_0_0_0, 32'h0, 32'h1008);
    add_entry(32'h1008, 32'h00209863, 32'h5, 32'h6, 5'b0_0_0_0_1, 32'h0, 32'h1018);
    add_entry(32'h100c, 32'h00209863, 32'h7, 32'h7, 5'b0_0_0_0_0, 32'h0, 32'h1010);
    // Signed compares with -1 against 1
    add_entry(32'h1010, 32'h0020c863, 32'hffffffff, 32'h1, 5'b0_0_0_0_1, 32'h0, 32'h1020);
    add_entry(32'h1014, 32'h0020c863, 32'h1, 32'hffffffff, 5'b0_0_0_0_0, 32'h0, 32'h1018);
    add_entry(32'h1018, 32'h0020d863, 32'h1, 32'hffffffff, 5'b0_0_0_0_1, 32'h0, 32'h1028);
    add_entry(32'h101c, 32'h0020d863, 32'hffffffff, 32'h1, 5'b0_0_0_0_0, 32'h0, 32'h1020);
    // Unsigned compares where the same operands flip the outcome
    add_entry(32'h1020, 32'h0020e863, 32'h1, 32'hffffffff, 5'b0_0_0_0_1, 32'h0, 32'h1030);
    add_entry(32'h1024, 32'h0020e863, 32'hffffffff, 32'h1, 5'b0_0_0_0_0, 32'h0, 32'h1028);
    add_entry(32'h1028, 32'h0020f863, 32'hffffffff, 32'h1, 5'b0_0_0_0_1, 32'h0, 32'h1038);
    add_entry(32'h102c, 32'h0020f863, 32'h1, 32'hffffffff, 5'b0_0_0_0_0, 32'h0, 32'h1030);
    // Backward bne trains the counter through WT, ST, WT and WNT
    add_entry(32'h1030, 32'hfe209ce3, 32'h1, 32'h2, 5'b0_0_0_0_1, 32'h0, 32'h1028);
    add_entry(32'h1030, 32'hfe209ce3, 32'h1, 32'h2, 5'b0_1_1_0_0, 32'h1028, 32'h1028);
    add_entry(32'h1030, 32'hfe209ce3, 32'h3, 32'h3, 5'b0_1_1_0_1, 32'h1028, 32'h1034);
    add_entry(32'h1030, 32'hfe209ce3, 32'h3, 32'h3, 5'b0_1_1_0_1, 32'h1028, 32'h1034);
    add_entry(32'h1030, 32'hfe209ce3, 32'h3, 32'h3, 5'b0_1_0_0_0, 32'h1028, 32'h1034);
    // jal ra, 256
    add_entry(32'h1034, 32'h100000ef, 32'h0, 32'h0, 5'b0_0_0_0_1, 32'h0, 32'h1134);
    add_entry(32'h1034, 32'h100000ef, 32'h0, 32'h0, 5'b0_1_1_0_0, 32'h1134, 32'h1134);
    // Return through jalr x0, 4(x1) whose rs1 later moves
    add_entry(32'h1038, 32'h00408067, 32'h2001, 32'h0, 5'b0_0_0_0_1, 32'h0, 32'h2004);
    add_entry(32'h1038, 32'h00408067, 32'h2001, 32'h0, 5'b0_1_1_1_0, 32'h2004, 32'h2004);
    add_entry(32'h1038, 32'h00408067, 32'h3000, 32'h0, 5'b0_1_1_1_1, 32'h2004, 32'h3004);
    // jalr ra, 0(t0) is never trained
    add_entry(32'h103c, 32'h000280e7, 32'h4000, 32'h0, 5'b0_0_0_0_1, 32'h0, 32'h4000);
    add_entry(32'h103c, 32'h000280e7, 32'h4000, 32'h0, 5'b0_0_0_0_1, 32'h0, 32'h4000);
    // addi at an unused pc with the middle row fed a taken prediction
    add_entry(32'h207c, 32'h00100093, 32'h0, 32'h0, 5'b0_0_0_0_0, 32'h0, 32'h2080);
    add_entry(32'h207c, 32'h00100093, 32'h0, 32'h0, 5'b1_0_0_0_1, 32'h3000, 32'h2080);
    add_entry(32'h207c, 32'h00100093, 32'h0, 32'h0, 5'b0_0_0_0_0, 32'h0, 32'h2080);
    // 0x1400 aliases index 0 with another tag and evicts 0x1000
    add_entry(32'h1000, 32'h00208863, 32'h5, 32'h5, 5'b0_1_1_0_0, 32'h1010, 32'h1010);
    add_entry(32'h1400, 32'h00208863, 32'h1, 32'h2, 5'b0_0_0_0_0, 32'h0, 32'h1404);
    add_entry(32'h1400, 32'h00208863, 32'h1, 32'h2, 5'b0_1_0_0_0, 32'h1410, 32'h1404);
    add_entry(32'h1000, 32'h00208863, 32'h5, 32'h5, 5'b0_0_0_0_1, 32'h0, 32'h1010);
  endfunction

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    assert (actual == expected) else begin
      $display("error %0t ns: %s expected %h actual %h", $time, name, expected, actual);
      $display("Checks failed");
      $fatal(1, "stopping at the first mismatch");
    end
  endtask

  // MEM result shows up one cycle after the EX slot
  task automatic wait_mem_valid();
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!mem_valid && cycles < 4);
    assert (mem_valid) else begin
      $display("Timeout at %0t ns: mem_valid never rose within 4 cycles", $time);
      $display("Checks failed");
      $fatal(1, "stopping on timeout");
    end
  endtask

  task automatic run_entry(input entry_t e);
    logic        seen_taken;
    logic [31:0] seen_target;
    // Fetch lookup
    @(posedge clk);
    fetch_pc <= e.pc;
    @(negedge clk);
    check_value("pred_hit", 32'(e.flags[3]), 32'(pred_hit));
    check_value("pred_taken", 32'(e.flags[2]), 32'(pred_taken));
    check_value("pred_is_ret", 32'(e.flags[1]), 32'(pred_is_ret));
    // Stored target is meaningless on a miss
    if (e.flags[3]) begin
      check_value("pred_target", e.target, pred_target);
    end
    seen_taken  = pred_taken;
    seen_target = pred_target;
    // EX slot carries the fetch prediction unless the row forces one
    @(posedge clk);
    ex_valid <= 1'b1;
    ex_instr <= e.instr;
    ex_pc    <= e.pc;
    ex_rs1   <= e.rs1;
    ex_rs2   <= e.rs2;
    if (e.flags[4]) begin
      ex_pred_taken  <= 1'b1;
      ex_pred_target <= e.target;
    end else begin
      ex_pred_taken  <= seen_taken;
      ex_pred_target <= seen_target;
    end
    @(posedge clk);
    ex_valid <= 1'b0;
    wait_mem_valid();
    check_value("mem_mispredict", 32'(e.flags[0]), 32'(mem_mispredict));
    check_value("mem_redirect_pc", e.redirect, mem_redirect_pc);
  endtask

  initial begin
    arst_n         = 1'b0;
    fetch_pc       = 32'h0;
    ex_valid       = 1'b0;
    ex_instr       = 32'h0;
    ex_pc          = 32'h0;
    ex_rs1         = 32'h0;
    ex_rs2         = 32'h0;
    ex_pred_taken  = 1'b0;
    ex_pred_target = 32'h0;
    fill_table();
    repeat (5) @(posedge clk);
    arst_n <= 1'b1;
    // Empty MEM slot right after reset
    @(negedge clk);
    check_value("mem_valid", 32'h0, 32'(mem_valid));
    check_value("mem_mispredict", 32'h0, 32'(mem_mispredict));
    foreach (table_q[i]) begin
      run_entry(table_q[i]);
    end
    $display("All checks passed");
    $finish;
  end

endmodule

//--- sim.f
src/rv_isa_pkg.sv
src/rv_bpred_pkg.sv
src/rv_branch_decode.sv
src/rv_branch_execute.sv
src/rv_bpred_ex.sv
src/rv_btb.sv
src/rv_bpred_mem.sv
src/rv_bpred_unit.sv
tests/rv_bpred_unit_assertions.sv
tests/rv_bpred_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# Compile and run the branch predictor testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module rv_bpred_unit_tb \
  -f sim.f \
  -o rv_bpred_unit_sim

# Exit status of the simulation is the test result
./obj_dir/rv_bpred_unit_sim
